// ==== hw/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word types

  typedef logic [31:0] fp_word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  rm_t;
  typedef logic [4:0]  fflags_t;     // NV DZ OF UF NX, NX in bit 0
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [3:0] {
    op_none,
    op_fsgnj,
    op_fsgnjn,
    op_fsgnjx,
    op_fmv_f2i,
    op_fclass,
    op_fmv_i2f,
    op_fcvt_w,
    op_fcvt_wu
  } fpu_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_exec,
    st_convert,
    st_retire
  } seq_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings

  localparam logic [6:0] opcode_fp      = 7'b1010011;
  localparam logic [1:0] fmt_single     = 2'b00;
  localparam logic [4:0] funct_sgnj     = 5'b00100;
  localparam logic [4:0] funct_fmv_f2i  = 5'b11100;  // Shared with fclass
  localparam logic [4:0] funct_fmv_i2f  = 5'b11110;
  localparam logic [4:0] funct_fcvt_i2f = 5'b11010;

  localparam rm_t rm_rne = 3'b000;
  localparam rm_t rm_rtz = 3'b001;
  localparam rm_t rm_dyn = 3'b111;

  localparam csr_addr_t csr_fflags = 12'h001;
  localparam csr_addr_t csr_frm    = 12'h002;
  localparam csr_addr_t csr_fcsr   = 12'h003;

endpackage

`default_nettype wire

// ==== hw/fpu_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fpu_op_if;

  logic              start;        // One cycle, conversions only
  fpu_pkg::fpu_op_e  op;
  fpu_pkg::fp_word_t src1;
  fpu_pkg::fp_word_t src2;
  fpu_pkg::fp_word_t int_src;
  fpu_pkg::rm_t      rm;           // Already resolved against frm
  fpu_pkg::fp_word_t sign_result;
  fpu_pkg::fp_word_t cvt_result;
  logic              cvt_nx;
  logic              cvt_done;

  modport seq (
    output start, op, src1, src2, int_src, rm,
    input  sign_result, cvt_result, cvt_nx, cvt_done
  );

  modport unit (
    input  start, op, src1, src2, int_src, rm,
    output sign_result, cvt_result, cvt_nx, cvt_done
  );

endinterface

`default_nettype wire

// ==== hw/fpu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_decoder (
  input  fpu_pkg::instr_t    instr_i,
  output fpu_pkg::fpu_op_e   op_o,
  output fpu_pkg::reg_addr_t rs1_o,
  output fpu_pkg::reg_addr_t rs2_o,
  output fpu_pkg::reg_addr_t rd_o,
  output fpu_pkg::rm_t       rm_o,
  output logic               int_dest_o,
  output logic               legal_o
);

  logic [6:0]         opcode;
  logic [6:0]         funct7;
  fpu_pkg::rm_t       rm;
  fpu_pkg::reg_addr_t rs2;
  logic               rm_cvt_ok;

  assign opcode = instr_i[6:0];
  assign funct7 = instr_i[31:25];
  assign rm     = instr_i[14:12];
  assign rs2    = instr_i[24:20];

  assign rd_o  = instr_i[11:7];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = rs2;
  assign rm_o  = rm;

  // Dynamic rm passes here, frm is checked at issue
  assign rm_cvt_ok = (rm == fpu_pkg::rm_rne) || (rm == fpu_pkg::rm_rtz) ||
                     (rm == fpu_pkg::rm_dyn);

  always_comb begin
    op_o       = fpu_pkg::op_none;
    int_dest_o = 1'b0;
    if (opcode == fpu_pkg::opcode_fp && funct7[1:0] == fpu_pkg::fmt_single) begin
      case (funct7[6:2])
        fpu_pkg::funct_sgnj: begin
          case (rm)
            3'b000:  op_o = fpu_pkg::op_fsgnj;
            3'b001:  op_o = fpu_pkg::op_fsgnjn;
            3'b010:  op_o = fpu_pkg::op_fsgnjx;
            default: op_o = fpu_pkg::op_none;
          endcase
        end
        fpu_pkg::funct_fmv_f2i: begin
          int_dest_o = 1'b1;
          if (rs2 == '0 && rm == 3'b000) begin
            op_o = fpu_pkg::op_fmv_f2i;
          end else if (rs2 == '0 && rm == 3'b001) begin
            op_o = fpu_pkg::op_fclass;
          end
        end
        fpu_pkg::funct_fmv_i2f: begin
          if (rs2 == '0 && rm == 3'b000) begin
            op_o = fpu_pkg::op_fmv_i2f;
          end
        end
        fpu_pkg::funct_fcvt_i2f: begin
          if (rm_cvt_ok && rs2 == 5'd0) begin
            op_o = fpu_pkg::op_fcvt_w;
          end else if (rm_cvt_ok && rs2 == 5'd1) begin
            op_o = fpu_pkg::op_fcvt_wu;
          end
        end
        default: op_o = fpu_pkg::op_none;
      endcase
    end
  end

  assign legal_o = (op_o != fpu_pkg::op_none);

endmodule

`default_nettype wire

// ==== hw/fpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_regfile (
  input  logic               clock,
  input  logic               reset,
  input  fpu_pkg::reg_addr_t raddr1_i,
  input  fpu_pkg::reg_addr_t raddr2_i,
  output fpu_pkg::fp_word_t  rdata1_o,
  output fpu_pkg::fp_word_t  rdata2_o,
  input  logic               wren_i,
  input  fpu_pkg::reg_addr_t waddr_i,
  input  fpu_pkg::fp_word_t  wdata_i
);

  fpu_pkg::fp_word_t regs [32];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wren_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // f0 is an ordinary register, unlike x0
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

// ==== hw/fpu_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_csr (
  input  logic               clock,
  input  logic               reset,
  input  fpu_pkg::csr_addr_t csr_addr_i,
  input  logic               csr_wren_i,
  input  fpu_pkg::fp_word_t  csr_wdata_i,
  output fpu_pkg::fp_word_t  csr_rdata_o,
  input  logic               flag_set_i,
  input  logic               flag_nx_i,
  output fpu_pkg::rm_t       frm_o
);

  fpu_pkg::fflags_t fflags_q;
  fpu_pkg::rm_t     frm_q;

  always_comb begin
    case (csr_addr_i)
      fpu_pkg::csr_fflags: csr_rdata_o = {27'b0, fflags_q};
      fpu_pkg::csr_frm:    csr_rdata_o = {29'b0, frm_q};
      fpu_pkg::csr_fcsr:   csr_rdata_o = {24'b0, frm_q, fflags_q};
      default:             csr_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fflags_q <= '0;
      frm_q    <= fpu_pkg::rm_rne;
    end else begin
      if (flag_set_i) begin
        fflags_q <= fflags_q | {4'b0000, flag_nx_i};   // Accrued, never cleared here
      end
      // Later assignments win over the flag update
      if (csr_wren_i) begin
        case (csr_addr_i)
          fpu_pkg::csr_fflags: fflags_q <= csr_wdata_i[4:0];
          fpu_pkg::csr_frm:    frm_q <= csr_wdata_i[2:0];
          fpu_pkg::csr_fcsr: begin
            fflags_q <= csr_wdata_i[4:0];
            frm_q    <= csr_wdata_i[7:5];
          end
          default: ;
        endcase
      end
    end
  end

  assign frm_o = frm_q;

endmodule

`default_nettype wire

// ==== hw/fpu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer (
  input  logic               clock,
  input  logic               reset,
  input  logic               instr_valid_i,
  input  fpu_pkg::fpu_op_e   op_i,
  input  fpu_pkg::reg_addr_t rd_i,
  input  logic               int_dest_i,
  input  logic               legal_i,
  input  fpu_pkg::rm_t       rm_i,
  input  fpu_pkg::rm_t       frm_i,
  input  fpu_pkg::fp_word_t  rdata1_i,
  input  fpu_pkg::fp_word_t  rdata2_i,
  input  fpu_pkg::fp_word_t  int_rs1_i,
  output logic               ready_o,
  output logic               done_o,
  output logic               illegal_o,
  output logic               int_wren_o,
  output fpu_pkg::fp_word_t  int_wdata_o,
  output logic               rf_wren_o,
  output fpu_pkg::reg_addr_t rf_waddr_o,
  output fpu_pkg::fp_word_t  rf_wdata_o,
  output logic               flag_set_o,
  output logic               flag_nx_o,
  fpu_op_if.seq              op_bus
);

  fpu_pkg::seq_state_e state;
  fpu_pkg::fpu_op_e    op_q;
  fpu_pkg::rm_t        rm_q;
  fpu_pkg::rm_t        rm_res;
  fpu_pkg::reg_addr_t  rd_q;
  fpu_pkg::fp_word_t   src1_q;
  fpu_pkg::fp_word_t   src2_q;
  fpu_pkg::fp_word_t   int_q;
  fpu_pkg::fp_word_t   res_q;
  logic                nx_q;
  logic                start_q;
  logic                illegal_q;
  logic                int_dest_q;
  logic                accept;
  logic                is_conv;
  logic                rm_bad;

  assign accept  = instr_valid_i && (state == fpu_pkg::st_idle);
  assign is_conv = (op_i == fpu_pkg::op_fcvt_w) || (op_i == fpu_pkg::op_fcvt_wu);
  assign rm_res  = (rm_i == fpu_pkg::rm_dyn) ? frm_i : rm_i;
  assign rm_bad  = is_conv && (rm_res != fpu_pkg::rm_rne) && (rm_res != fpu_pkg::rm_rtz);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= fpu_pkg::st_idle;
      op_q       <= fpu_pkg::op_none;
      rm_q       <= fpu_pkg::rm_rne;
      start_q    <= 1'b0;
      illegal_q  <= 1'b0;
      int_dest_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state)
        fpu_pkg::st_idle: begin
          if (accept) begin
            op_q       <= op_i;
            rm_q       <= rm_res;
            int_dest_q <= int_dest_i;
            illegal_q  <= !legal_i || rm_bad;
            if (legal_i && !rm_bad && is_conv) begin
              state   <= fpu_pkg::st_convert;
              start_q <= 1'b1;                 // Counter loads at the end of the next cycle
            end else begin
              state <= fpu_pkg::st_exec;
            end
          end
        end
        fpu_pkg::st_exec:    state <= fpu_pkg::st_idle;
        fpu_pkg::st_convert: begin
          if (op_bus.cvt_done) begin
            state <= fpu_pkg::st_retire;
          end
        end
        fpu_pkg::st_retire:  state <= fpu_pkg::st_idle;
        default:             state <= fpu_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rd_q   <= rd_i;
      src1_q <= rdata1_i;
      src2_q <= rdata2_i;
      int_q  <= int_rs1_i;
    end
    if (state == fpu_pkg::st_convert && op_bus.cvt_done) begin
      res_q <= op_bus.cvt_result;
      nx_q  <= op_bus.cvt_nx;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch and retirement

  assign op_bus.start   = start_q;
  assign op_bus.op      = op_q;
  assign op_bus.src1    = src1_q;
  assign op_bus.src2    = src2_q;
  assign op_bus.int_src = int_q;
  assign op_bus.rm      = rm_q;

  assign ready_o     = (state == fpu_pkg::st_idle);
  assign done_o      = (state == fpu_pkg::st_exec && !illegal_q) ||
                       (state == fpu_pkg::st_retire);
  assign illegal_o   = (state == fpu_pkg::st_exec) && illegal_q;
  assign int_wren_o  = (state == fpu_pkg::st_exec) && !illegal_q && int_dest_q;
  assign int_wdata_o = op_bus.sign_result;

  assign rf_wren_o  = done_o && !int_dest_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = (state == fpu_pkg::st_retire) ? res_q : op_bus.sign_result;
  assign flag_set_o = (state == fpu_pkg::st_retire);
  assign flag_nx_o  = nx_q;

endmodule

`default_nettype wire

// ==== hw/fpu_norm_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_norm_counter (
  input logic    clock,
  input logic    reset,
  fpu_op_if.unit op_bus
);

  fpu_pkg::fp_word_t mag;
  fpu_pkg::fp_word_t val_q;
  logic [4:0]        cnt_q;
  logic [7:0]        exp;
  logic [30:0]       rounded;
  logic              neg;
  logic              sign_q;
  logic              shifting_q;
  logic              finish_q;
  logic              round_up;

  assign neg = (op_bus.op == fpu_pkg::op_fcvt_w) && op_bus.int_src[31];
  assign mag = neg ? -op_bus.int_src : op_bus.int_src;   // -2^31 stays 0x80000000

  always_ff @(posedge clock) begin
    if (!reset) begin
      shifting_q <= 1'b0;
      finish_q   <= 1'b0;
    end else begin
      finish_q <= 1'b0;
      if (op_bus.start) begin
        shifting_q <= (mag != '0) && !mag[31];
        finish_q   <= (mag == '0) || mag[31];
      end else if (shifting_q && val_q[30]) begin
        shifting_q <= 1'b0;                    // Bit 31 is set after this shift
        finish_q   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (op_bus.start) begin
      val_q  <= mag;
      cnt_q  <= '0;
      sign_q <= neg;
    end else if (shifting_q) begin
      val_q <= val_q << 1;
      cnt_q <= cnt_q + 5'd1;
    end
  end

  // Rounding happens in the done cycle on the normalized value
  assign exp      = 8'd158 - {3'b000, cnt_q};
  assign round_up = (op_bus.rm == fpu_pkg::rm_rne) && val_q[7] &&
                    ((|val_q[6:0]) || val_q[8]);
  assign rounded  = {exp, val_q[30:8]} + {30'b0, round_up};   // Carry bumps the exponent

  assign op_bus.cvt_result = (val_q == '0) ? '0 : {sign_q, rounded};
  assign op_bus.cvt_nx     = |val_q[7:0];
  assign op_bus.cvt_done   = finish_q;

endmodule

`default_nettype wire

// ==== hw/fpu_sign_ops.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_sign_ops (
  fpu_op_if.unit op_bus
);

  logic [7:0]        exp;
  logic [22:0]       man;
  logic              sign;
  logic              exp_ones;
  logic              exp_zero;
  logic              man_zero;
  logic [9:0]        class_mask;
  fpu_pkg::fp_word_t result;

  assign sign     = op_bus.src1[31];
  assign exp      = op_bus.src1[30:23];
  assign man      = op_bus.src1[22:0];
  assign exp_ones = &exp;
  assign exp_zero = ~|exp;
  assign man_zero = ~|man;

  // Bit order follows the RISC-V fclass mask
  assign class_mask[0] = sign && exp_ones && man_zero;
  assign class_mask[1] = sign && !exp_zero && !exp_ones;
  assign class_mask[2] = sign && exp_zero && !man_zero;
  assign class_mask[3] = sign && exp_zero && man_zero;
  assign class_mask[4] = !sign && exp_zero && man_zero;
  assign class_mask[5] = !sign && exp_zero && !man_zero;
  assign class_mask[6] = !sign && !exp_zero && !exp_ones;
  assign class_mask[7] = !sign && exp_ones && man_zero;
  assign class_mask[8] = exp_ones && !man_zero && !man[22];
  assign class_mask[9] = exp_ones && man[22];

  always_comb begin
    case (op_bus.op)
      fpu_pkg::op_fsgnj:   result = {op_bus.src2[31], op_bus.src1[30:0]};
      fpu_pkg::op_fsgnjn:  result = {~op_bus.src2[31], op_bus.src1[30:0]};
      fpu_pkg::op_fsgnjx:  result = {sign ^ op_bus.src2[31], op_bus.src1[30:0]};
      fpu_pkg::op_fmv_f2i: result = op_bus.src1;
      fpu_pkg::op_fmv_i2f: result = op_bus.int_src;
      fpu_pkg::op_fclass:  result = {22'b0, class_mask};
      default:             result = '0;
    endcase
  end

  assign op_bus.sign_result = result;

endmodule

`default_nettype wire

// ==== hw/fpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               instr_valid_i,
  input  fpu_pkg::instr_t    instr_i,
  input  fpu_pkg::fp_word_t  int_rs1_i,
  input  fpu_pkg::csr_addr_t csr_addr_i,
  input  logic               csr_wren_i,
  input  fpu_pkg::fp_word_t  csr_wdata_i,
  output logic               ready_o,
  output logic               done_o,
  output logic               illegal_o,
  output logic               int_wren_o,
  output fpu_pkg::fp_word_t  int_wdata_o,
  output fpu_pkg::fp_word_t  csr_rdata_o
);

  fpu_pkg::fpu_op_e   dec_op;
  fpu_pkg::reg_addr_t dec_rs1;
  fpu_pkg::reg_addr_t dec_rs2;
  fpu_pkg::reg_addr_t dec_rd;
  fpu_pkg::rm_t       dec_rm;
  logic               dec_int_dest;
  logic               dec_legal;
  fpu_pkg::fp_word_t  rdata1;
  fpu_pkg::fp_word_t  rdata2;
  logic               rf_wren;
  fpu_pkg::reg_addr_t rf_waddr;
  fpu_pkg::fp_word_t  rf_wdata;
  fpu_pkg::rm_t       frm;
  logic               flag_set;
  logic               flag_nx;

  fpu_op_if op_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Decode, state and control

  fpu_decoder decoder0 (
    .instr_i    (instr_i),
    .op_o       (dec_op),
    .rs1_o      (dec_rs1),
    .rs2_o      (dec_rs2),
    .rd_o       (dec_rd),
    .rm_o       (dec_rm),
    .int_dest_o (dec_int_dest),
    .legal_o    (dec_legal)
  );

  fpu_regfile regfile0 (
    .clock    (clock),
    .reset    (reset),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wren_i   (rf_wren),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  fpu_csr csr0 (
    .clock       (clock),
    .reset       (reset),
    .csr_addr_i  (csr_addr_i),
    .csr_wren_i  (csr_wren_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .flag_set_i  (flag_set),
    .flag_nx_i   (flag_nx),
    .frm_o       (frm)
  );

  fpu_sequencer sequencer0 (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .op_i          (dec_op),
    .rd_i          (dec_rd),
    .int_dest_i    (dec_int_dest),
    .legal_i       (dec_legal),
    .rm_i          (dec_rm),
    .frm_i         (frm),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .int_rs1_i     (int_rs1_i),
    .ready_o       (ready_o),
    .done_o        (done_o),
    .illegal_o     (illegal_o),
    .int_wren_o    (int_wren_o),
    .int_wdata_o   (int_wdata_o),
    .rf_wren_o     (rf_wren),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .flag_set_o    (flag_set),
    .flag_nx_o     (flag_nx),
    .op_bus        (op_bus.seq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execution units

  fpu_norm_counter norm_counter0 (
    .clock  (clock),
    .reset  (reset),
    .op_bus (op_bus.unit)
  );

  fpu_sign_ops sign_ops0 (
    .op_bus (op_bus.unit)
  );

endmodule

`default_nettype wire

// ==== verification/fpu_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  localparam int half_period  = 5;
  localparam int reset_cycles = 10;

  initial begin
    clock_o = 1'b0;
    forever #half_period clock_o = ~clock_o;
  end

  initial begin
    reset_o = 1'b0;
    repeat (reset_cycles) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b1;                          // Released between two rising edges
  end

endmodule

`default_nettype wire

// ==== verification/fpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_checker (
  input logic clock,
  input logic reset,
  input logic instr_valid_i,
  input logic ready_i,
  input logic done_i,
  input logic illegal_i,
  input logic int_wren_i
);

  int unsigned fail_count = 0;

  done_or_illegal: assert property (@(posedge clock) disable iff (!reset)
    !(done_i && illegal_i))
    else begin
      $error("done_o and illegal_o are high in the same cycle");
      fail_count++;
    end

  int_wren_with_done: assert property (@(posedge clock) disable iff (!reset)
    int_wren_i |-> done_i)
    else begin
      $error("int_wren_o is high without done_o");
      fail_count++;
    end

  // The unit holds one instruction at a time
  busy_after_accept: assert property (@(posedge clock) disable iff (!reset)
    (instr_valid_i && ready_i) |=> !ready_i)
    else begin
      $error("ready_o stayed high in the cycle after acceptance");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/fpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

  localparam int n_tests        = 300;
  localparam int reset_cycles   = 10;
  localparam int max_latency    = 40;
  localparam int timeout_cycles = (n_tests + 2 * 32 + 8) * 40 + reset_cycles;

  localparam logic [6:0] fp_opcode = 7'b1010011;
  localparam logic [4:0] f5_sgnj   = 5'b00100;
  localparam logic [4:0] f5_mv_x_w = 5'b11100;
  localparam logic [4:0] f5_mv_w_x = 5'b11110;
  localparam logic [4:0] f5_cvt    = 5'b11010;

  localparam int op_illegal = 0;
  localparam int op_fsgnj   = 1;
  localparam int op_fsgnjn  = 2;
  localparam int op_fsgnjx  = 3;
  localparam int op_mv_x_w  = 4;
  localparam int op_class   = 5;
  localparam int op_mv_w_x  = 6;
  localparam int op_cvt_w   = 7;
  localparam int op_cvt_wu  = 8;

  logic        clock;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] int_rs1;
  logic [11:0] csr_addr;
  logic        csr_wren;
  logic [31:0] csr_wdata;
  logic        ready;
  logic        done;
  logic        illegal;
  logic        int_wren;
  logic [31:0] int_wdata;
  logic [31:0] csr_rdata;

  logic [31:0] model_regs [32];
  logic [2:0]  model_frm;
  logic [4:0]  model_fflags;

  fpu_clock_gen clock_gen0 (
    .clock_o (clock),
    .reset_o (reset)
  );

  fpu_top dut0 (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .int_rs1_i     (int_rs1),
    .csr_addr_i    (csr_addr),
    .csr_wren_i    (csr_wren),
    .csr_wdata_i   (csr_wdata),
    .ready_o       (ready),
    .done_o        (done),
    .illegal_o     (illegal),
    .int_wren_o    (int_wren),
    .int_wdata_o   (int_wdata),
    .csr_rdata_o   (csr_rdata)
  );

  bind fpu_top fpu_checker checker0 (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .ready_i       (ready_o),
    .done_i        (done_o),
    .illegal_i     (illegal_o),
    .int_wren_i    (int_wren_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] encode_fp(input logic [4:0] f5, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] rm,
                                            input logic [4:0] rd);
    return {f5, 2'b00, rs2, rs1, rm, rd, fp_opcode};
  endfunction

  function automatic int decode_instr(input logic [31:0] word);
    logic [2:0] rm;
    logic [4:0] rs2;
    int         op;
    rm  = word[14:12];
    rs2 = word[24:20];
    op  = op_illegal;
    if (word[6:0] == fp_opcode && word[26:25] == 2'b00) begin
      case (word[31:27])
        f5_sgnj: begin
          if (rm == 3'd0) op = op_fsgnj;
          else if (rm == 3'd1) op = op_fsgnjn;
          else if (rm == 3'd2) op = op_fsgnjx;
        end
        f5_mv_x_w: begin
          if (rs2 == 5'd0 && rm == 3'd0) op = op_mv_x_w;
          else if (rs2 == 5'd0 && rm == 3'd1) op = op_class;
        end
        f5_mv_w_x: if (rs2 == 5'd0 && rm == 3'd0) op = op_mv_w_x;
        f5_cvt: begin
          if (rm == 3'd0 || rm == 3'd1 || rm == 3'd7) begin
            if (rs2 == 5'd0) op = op_cvt_w;
            else if (rs2 == 5'd1) op = op_cvt_wu;
          end
        end
        default: op = op_illegal;
      endcase
    end
    return op;
  endfunction

  function automatic logic [31:0] expected_class(input logic [31:0] x);
    logic [7:0]  e;
    logic [22:0] m;
    int          bit_pos;
    e = x[30:23];
    m = x[22:0];
    if (e == 8'hff && m != 0) bit_pos = m[22] ? 9 : 8;
    else if (e == 8'hff) bit_pos = x[31] ? 0 : 7;
    else if (e == 8'h00 && m == 0) bit_pos = x[31] ? 3 : 4;
    else if (e == 8'h00) bit_pos = x[31] ? 2 : 5;
    else bit_pos = x[31] ? 1 : 6;
    return 32'd1 << bit_pos;
  endfunction

  task automatic convert_int(input logic [31:0] val, input logic is_signed,
                             input logic [2:0] rm, output logic [31:0] res, output logic nx);
    logic        sign;
    logic        up;
    logic [31:0] norm;
    logic [30:0] body;
    int          k;
    sign = is_signed && val[31];
    norm = sign ? (~val + 32'd1) : val;
    res  = 32'h0;
    nx   = 1'b0;
    if (norm != 32'h0) begin
      k = 0;
      while (!norm[31]) begin
        norm = norm << 1;
        k++;
      end
      nx   = |norm[7:0];
      up   = (rm == 3'd0) && norm[7] && ((|norm[6:0]) || norm[8]);   // Ties go to even
      body = {8'(158 - k), norm[30:8]} + {30'b0, up};
      res  = {sign, body};
    end
  endtask

  task automatic predict(input logic [31:0] word, input logic [31:0] rs1_val,
                         output logic exp_ill, output logic exp_wren,
                         output logic [31:0] exp_data);
    int          op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [2:0]  rm;
    logic        nx;
    op       = decode_instr(word);
    a        = model_regs[word[19:15]];
    b        = model_regs[word[24:20]];
    rm       = (word[14:12] == 3'd7) ? model_frm : word[14:12];
    exp_ill  = 1'b0;
    exp_wren = 1'b0;
    exp_data = 32'h0;
    case (op)
      op_fsgnj:  model_regs[word[11:7]] = {b[31], a[30:0]};
      op_fsgnjn: model_regs[word[11:7]] = {~b[31], a[30:0]};
      op_fsgnjx: model_regs[word[11:7]] = {a[31] ^ b[31], a[30:0]};
      op_mv_x_w: begin
        exp_wren = 1'b1;
        exp_data = a;
      end
      op_class: begin
        exp_wren = 1'b1;
        exp_data = expected_class(a);
      end
      op_mv_w_x: model_regs[word[11:7]] = rs1_val;
      op_cvt_w, op_cvt_wu: begin
        if (rm != 3'd0 && rm != 3'd1) begin
          exp_ill = 1'b1;
        end else begin
          convert_int(rs1_val, op == op_cvt_w, rm, res, nx);
          model_regs[word[11:7]] = res;
          model_fflags[0] = model_fflags[0] | nx;
        end
      end
      default: exp_ill = 1'b1;
    endcase
  endtask

  function automatic logic [31:0] csr_expected(input logic [11:0] addr);
    case (addr)
      12'h001: return {27'b0, model_fflags};
      12'h002: return {29'b0, model_frm};
      12'h003: return {24'b0, model_frm, model_fflags};
      default: return 32'h0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic issue_instr(input logic [31:0] word, input logic [31:0] rs1_val,
                             output logic got_done, output logic got_ill,
                             output logic got_wren, output logic [31:0] got_data);
    int waited;
    waited = 0;
    while (!ready) @(negedge clock);
    instr_valid = 1'b1;
    instr       = word;
    int_rs1     = rs1_val;
    @(negedge clock);
    instr_valid = 1'b0;
    while (!done && !illegal) begin
      waited++;
      assert (waited <= max_latency) else begin
        $display("Instruction 0x%08h got neither done_o nor illegal_o within %0d cycles",
                 word, max_latency);
        abort_run();
      end
      @(negedge clock);
    end
    got_done = done;
    got_ill  = illegal;
    got_wren = int_wren;
    got_data = int_wdata;
    @(negedge clock);
    check_word("ready_o", ready, 1'b1);
  endtask

  task automatic run_instr(input logic [31:0] word, input logic [31:0] rs1_val);
    logic        exp_ill;
    logic        exp_wren;
    logic        got_done;
    logic        got_ill;
    logic        got_wren;
    logic [31:0] exp_data;
    logic [31:0] got_data;
    predict(word, rs1_val, exp_ill, exp_wren, exp_data);
    issue_instr(word, rs1_val, got_done, got_ill, got_wren, got_data);
    check_word("illegal_o", got_ill, exp_ill);
    check_word("done_o", got_done, !exp_ill);
    check_word("int_wren_o", got_wren, exp_wren);
    if (exp_wren) check_word("int_wdata_o", got_data, exp_data);
  endtask

  task automatic read_reg(input logic [4:0] r);
    run_instr(encode_fp(f5_mv_x_w, 5'd0, r, 3'd0, 5'd1), 32'h0);
  endtask

  task automatic check_csr(input logic [11:0] addr);
    csr_addr = addr;
    @(negedge clock);
    check_word($sformatf("csr_rdata_o at 0x%03h", addr), csr_rdata, csr_expected(addr));
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
    csr_addr  = addr;
    csr_wdata = data;
    csr_wren  = 1'b1;
    @(negedge clock);
    csr_wren = 1'b0;
    if (addr == 12'h001 || addr == 12'h003) model_fflags = data[4:0];
    if (addr == 12'h002) model_frm = data[2:0];
    if (addr == 12'h003) model_frm = data[7:5];
  endtask

  function automatic logic [31:0] random_float();
    logic [31:0] word;
    word = $urandom();
    case ($urandom_range(0, 5))
      0: word[30:23] = 8'h00;                 // Zero or subnormal
      1: word[30:23] = 8'hff;                 // Infinity or NaN
      2: word[22:0] = 23'h0;
      3: word = {word[31], 31'h7f800000};
      default: ;
    endcase
    return word;
  endfunction

  function automatic logic [31:0] random_int();
    logic [31:0] word;
    word = $urandom() >> $urandom_range(0, 31);
    if ($urandom_range(0, 1) == 1) word = ~word + 32'd1;
    case ($urandom_range(0, 9))
      0: word = 32'h0;
      1: word = 32'h80000000;
      2: word = 32'hffffffff;
      default: ;
    endcase
    return word;
  endfunction

  function automatic logic [31:0] random_encoding();
    logic [31:0] word;
    word = $urandom();
    if ($urandom_range(0, 3) != 0) begin
      word[6:0] = fp_opcode;
      case ($urandom_range(0, 4))
        0: word[31:27] = f5_sgnj;
        1: word[31:27] = f5_mv_x_w;
        2: word[31:27] = f5_mv_w_x;
        3: word[31:27] = f5_cvt;
        default: ;
      endcase
      if ($urandom_range(0, 1) == 1) word[24:20] = 5'($urandom_range(0, 2));
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles", timeout_cycles);
    abort_run();
  end

  always @(negedge clock) begin
    assert (dut0.checker0.fail_count == 0) else begin
      $display("A bound assertion on the DUT ports failed");
      abort_run();
    end
  end

  initial begin
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  rm;
    logic [31:0] data;
    instr_valid = 1'b0;
    instr       = 32'h0;
    int_rs1     = 32'h0;
    csr_addr    = 12'h0;
    csr_wren    = 1'b0;
    csr_wdata   = 32'h0;
    for (int r = 0; r < 32; r++) model_regs[r] = 32'h0;
    model_frm    = 3'd0;
    model_fflags = 5'd0;
    void'($urandom(15177));
    wait (reset === 1'b1);
    @(negedge clock);

    for (int r = 0; r < 32; r++) read_reg(5'(r));
    check_csr(12'h003);

    for (int t = 0; t < n_tests; t++) begin
      kind = $urandom_range(0, 9);
      rd   = 5'($urandom());
      rs1  = 5'($urandom());
      case (kind)
        0, 1: run_instr(encode_fp(f5_mv_w_x, 5'd0, rs1, 3'd0, rd), random_float());
        2: read_reg(rs1);
        3: run_instr(encode_fp(f5_sgnj, 5'($urandom()), rs1, 3'($urandom_range(0, 2)), rd),
                     $urandom());
        4: run_instr(encode_fp(f5_mv_x_w, 5'd0, rs1, 3'd1, rd), $urandom());
        5, 6: begin
          case ($urandom_range(0, 2))
            0: rm = 3'd0;
            1: rm = 3'd1;
            default: rm = 3'd7;
          endcase
          run_instr(encode_fp(f5_cvt, 5'($urandom_range(0, 1)), rs1, rm, rd), random_int());
          read_reg(rd);
          check_csr(12'h001);
        end
        7: begin
          run_instr(random_encoding(), $urandom());
          check_csr(12'h003);
        end
        8: begin
          data = $urandom();
          if ($urandom_range(0, 1) == 1) begin
            data[7:5] = 3'($urandom_range(0, 1));   // Keep dynamic rounding usable
            data[2:0] = 3'($urandom_range(0, 1));
          end
          write_csr(12'($urandom_range(1, 3)), data);
          check_csr(12'h001);
          check_csr(12'h002);
          check_csr(12'h003);
        end
        default: check_csr(12'(16'h004 + $urandom_range(0, 4000)));
      endcase
    end

    for (int r = 0; r < 32; r++) read_reg(5'(r));
    check_csr(12'h001);
    check_csr(12'h002);
    check_csr(12'h003);

    if (dut0.checker0.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", dut0.checker0.fail_count);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/fpu_pkg.sv
hw/fpu_op_if.sv
hw/fpu_decoder.sv
hw/fpu_regfile.sv
hw/fpu_csr.sv
hw/fpu_sequencer.sv
hw/fpu_norm_counter.sv
hw/fpu_sign_ops.sv
hw/fpu_top.sv
verification/fpu_clock_gen.sv
verification/fpu_checker.sv
verification/fpu_tb.sv

// ==== Bender.yml ====
package:
  name: fpu_side_unit

sources:
  - files:
      - hw/fpu_pkg.sv
      - hw/fpu_op_if.sv
      - hw/fpu_decoder.sv
      - hw/fpu_regfile.sv
      - hw/fpu_csr.sv
      - hw/fpu_sequencer.sv
      - hw/fpu_norm_counter.sv
      - hw/fpu_sign_ops.sv
      - hw/fpu_top.sv
  - target: test
    files:
      - verification/fpu_clock_gen.sv
      - verification/fpu_checker.sv
      - verification/fpu_tb.sv
